/* verilog/obi_pkg.sv */
// OBI data port package with bus widths, request and response types and access sizes
`default_nettype none

package obi_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  // Byte address and data word width
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Request check code covers wdata, atop, dbg, be/we, prot/memtype and addr
  localparam int unsigned ACHK_W = 12;

  // Response check code covers rdata bytes and err
  localparam int unsigned RCHK_W = 5;

  // Upper half of memory is integrity protected
  localparam int unsigned INTEGRITY_ADDR_BIT = 31;

  //////////////////////////////
  // Access size
  //////////////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  //////////////////////////////
  // A and R channel payloads
  //////////////////////////////

  // A channel payload as seen on the bus
  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic                we;
    logic [DATA_W/8-1:0] be;
    logic [DATA_W-1:0]   wdata;
    // Transfer targets the protected region
    logic                integrity;
    logic [ACHK_W-1:0]   achk;
  } obi_req_t;

  // R channel payload plus the integrity status added by the adapter
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [RCHK_W-1:0] rchk;
    logic              integrity;
    // Any parity or check code fault tied to this response
    logic              integrity_err;
  } obi_resp_t;

endpackage

`default_nettype wire

/* verilog/trans_if.sv */
// Transaction request channel from the load/store front end to the OBI adapter
`default_nettype none

interface trans_if;

  // Request is offered while valid is high
  logic             valid;
  // Adapter accepts the request
  logic             ready;
  // Aligned request, payload held stable while valid
  obi_pkg::obi_req_t req;

  // Front end side
  modport front (
    output valid,
    output req,
    input  ready
  );

  // Adapter side
  modport adapter (
    input  valid,
    input  req,
    output ready
  );

endinterface

`default_nettype wire

/* verilog/obi_if.sv */
// OBI A and R channel bundle with handshake parity signals
`default_nettype none

interface obi_if;

  // A channel handshake and its inverted parity
  logic req;
  logic reqpar;
  logic gnt;
  logic gntpar;

  // R channel handshake, no back-pressure
  logic rvalid;
  logic rvalidpar;

  // Channel payloads
  obi_pkg::obi_req_t  req_payload;
  obi_pkg::obi_resp_t resp_payload;

  modport master (
    output req, reqpar, req_payload,
    input  gnt, gntpar, rvalid, rvalidpar, resp_payload
  );

  // Memory side
  modport slave (
    input  req, reqpar, req_payload,
    output gnt, gntpar, rvalid, rvalidpar, resp_payload
  );

endinterface

`default_nettype wire

/* verilog/obi_integrity_fifo.sv */
// Per-transfer queue of integrity attributes and grant faults with response check
`default_nettype none

module obi_integrity_fifo #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               gntpar_err_i,
  input  logic               trans_integrity_i,
  input  logic               trans_we_i,
  input  logic               obi_req_i,
  input  logic               obi_gnt_i,
  input  logic               obi_rvalid_i,
  input  obi_pkg::obi_resp_t obi_resp_i,
  output logic               gntpar_err_resp_o,
  output logic               integrity_resp_o,
  output logic               rchk_err_resp_o
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  typedef struct packed {
    logic integrity;
    logic we;
    logic gntpar_err;
  } entry_t;

  entry_t                    entry_mem [MAX_OUTSTANDING];
  entry_t                    head;
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          cnt;
  logic                      push;
  logic                      pop;
  logic [obi_pkg::RCHK_W-1:0] rchk_exp;

  // One entry per address phase, one per response
  assign push = obi_req_i && obi_gnt_i;
  assign pop  = obi_rvalid_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_mem[wr_ptr] <= '{integrity: trans_integrity_i, we: trans_we_i,
                             gntpar_err: gntpar_err_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr + 1'b1;
      end
      cnt <= cnt + CNT_W'(push) - CNT_W'(pop);
    end
  end

  //////////////////////////////
  // Response side
  //////////////////////////////

  assign head = entry_mem[rd_ptr];

  // Even parity per rdata byte, err on top
  assign rchk_exp = {
    ^obi_resp_i.err,
    ^obi_resp_i.rdata[31:24],
    ^obi_resp_i.rdata[23:16],
    ^obi_resp_i.rdata[15:8],
    ^obi_resp_i.rdata[7:0]
  };

  // Only valid in the rvalid cycle
  assign gntpar_err_resp_o = obi_rvalid_i && head.gntpar_err;
  assign integrity_resp_o  = obi_rvalid_i && head.integrity;
  // Writes carry no checked read data
  assign rchk_err_resp_o   = obi_rvalid_i && head.integrity && !head.we &&
                             (obi_resp_i.rchk != rchk_exp);

  // Bus must not grant beyond the front end limit
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   push && !pop |-> (cnt != CNT_W'(MAX_OUTSTANDING)))
    else $error("Integrity queue overflow");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop |-> (cnt != '0))
    else $error("Integrity queue underflow");

endmodule

`default_nettype wire

/* verilog/lsu_obi_front.sv */
// Load/store front end that aligns core requests and extends returned load data
`default_nettype none

module lsu_obi_front #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Core request side
  input  logic                        core_req_i,
  output logic                        core_ready_o,
  input  logic [obi_pkg::ADDR_W-1:0]  core_addr_i,
  input  logic                        core_we_i,
  input  obi_pkg::size_e              core_size_i,
  input  logic                        core_signed_i,
  input  logic [obi_pkg::DATA_W-1:0]  core_wdata_i,
  // Core response side
  output logic                        core_rvalid_o,
  output logic [obi_pkg::DATA_W-1:0]  core_rdata_o,
  output logic                        core_err_o,
  // Towards the adapter
  trans_if.front                      trans,
  input  logic                        resp_valid_i,
  input  obi_pkg::obi_resp_t          resp_i
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  // What the load extraction needs to know per transfer
  typedef struct packed {
    obi_pkg::size_e size;
    logic           sign;
    logic [1:0]     offset;
  } ld_info_t;

  ld_info_t                   info_mem [MAX_OUTSTANDING];
  ld_info_t                   rd_info;
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [CNT_W-1:0]           cnt;
  logic                       full;
  logic                       push;
  logic                       pop;
  logic [1:0]                 offset;
  logic [3:0]                 be;
  logic [obi_pkg::DATA_W-1:0] wdata_lane;
  logic [obi_pkg::DATA_W-1:0] rdata_sh;

  //////////////////////////////
  // Request alignment
  //////////////////////////////

  assign offset = core_addr_i[1:0];

  // Byte enables follow size and low address bits
  always_comb begin
    case (core_size_i)
      obi_pkg::SIZE_BYTE: be = 4'b0001 << offset;
      obi_pkg::SIZE_HALF: be = 4'b0011 << offset;
      default:            be = 4'b1111;
    endcase
  end

  // Write data moves onto its byte lanes
  assign wdata_lane = core_wdata_i << {offset, 3'b000};

  // Hold off the core once the response queue is full
  assign full         = (cnt == CNT_W'(MAX_OUTSTANDING));
  assign trans.valid  = core_req_i && !full;
  assign core_ready_o = trans.ready && !full;

  // achk is left to the adapter
  assign trans.req = '{
    addr:      core_addr_i,
    we:        core_we_i,
    be:        be,
    wdata:     wdata_lane,
    integrity: core_addr_i[obi_pkg::INTEGRITY_ADDR_BIT],
    achk:      '0
  };

  //////////////////////////////
  // Outstanding transfer queue
  //////////////////////////////

  assign push = trans.valid && trans.ready;
  assign pop  = resp_valid_i;

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      info_mem[wr_ptr] <= '{size: core_size_i, sign: core_signed_i, offset: offset};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr + 1'b1;
      end
      cnt <= cnt + CNT_W'(push) - CNT_W'(pop);
    end
  end

  //////////////////////////////
  // Load data extraction
  //////////////////////////////

  assign rd_info  = info_mem[rd_ptr];
  // Addressed byte down to lane 0
  assign rdata_sh = resp_i.rdata >> {rd_info.offset, 3'b000};

  always_comb begin
    case (rd_info.size)
      obi_pkg::SIZE_BYTE:
        core_rdata_o = {{(obi_pkg::DATA_W-8){rd_info.sign & rdata_sh[7]}}, rdata_sh[7:0]};
      obi_pkg::SIZE_HALF:
        core_rdata_o = {{(obi_pkg::DATA_W-16){rd_info.sign & rdata_sh[15]}}, rdata_sh[15:0]};
      default:
        core_rdata_o = rdata_sh;
    endcase
  end

  assign core_rvalid_o = resp_valid_i;
  // Bus error goes to the core as is
  assign core_err_o    = resp_i.err;

  // Every response belongs to a transfer granted earlier
  assert property (@(posedge clk_i) disable iff (!rst_n_i) resp_valid_i |-> (cnt != '0))
    else $error("Response with no outstanding transfer");

endmodule

`default_nettype wire

/* verilog/data_obi_interface.sv */
// OBI adapter adding request parity and check codes and merging integrity faults
`default_nettype none

module data_obi_interface #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  trans_if.adapter           trans,
  // Consumer is always ready for a response
  output logic               resp_valid_o,
  output obi_pkg::obi_resp_t resp_o,
  output logic               integrity_err_o,
  obi_if.master              obi
);

  obi_pkg::obi_req_t req_payload;
  logic              gntpar_err;
  logic              rvalidpar_err;
  logic              gntpar_err_resp;
  logic              integrity_resp;
  logic              rchk_err_resp;

  //////////////////////////////
  // A channel
  //////////////////////////////

  // Front end keeps the request stable, so it goes to the bus directly
  assign obi.req    = trans.valid;
  assign obi.reqpar = ~trans.valid;
  assign trans.ready = obi.gnt;

  always_comb begin
    req_payload      = trans.req;
    // Fields absent from this port count as zero
    req_payload.achk = {
      ^trans.req.wdata[31:24],
      ^trans.req.wdata[23:16],
      ^trans.req.wdata[15:8],
      ^trans.req.wdata[7:0],
      1'b0,
      1'b1,
      ~^{trans.req.be, trans.req.we},
      1'b1,
      ^trans.req.addr[31:24],
      ^trans.req.addr[23:16],
      ^trans.req.addr[15:8],
      ^trans.req.addr[7:0]
    };
  end

  assign obi.req_payload = req_payload;

  //////////////////////////////
  // R channel and integrity
  //////////////////////////////

  // Parity is good when it is the inverse of its signal
  assign gntpar_err    = (obi.gnt == obi.gntpar);
  assign rvalidpar_err = (obi.rvalid == obi.rvalidpar);

  assign resp_valid_o = obi.rvalid;

  always_comb begin
    resp_o               = obi.resp_payload;
    resp_o.integrity     = integrity_resp;
    resp_o.integrity_err = rvalidpar_err || gntpar_err_resp || rchk_err_resp;
  end

  // Grant faults are also flagged right away
  assign integrity_err_o = rvalidpar_err || gntpar_err || rchk_err_resp;

  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_obi_integrity_fifo (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .gntpar_err_i      (gntpar_err),
    .trans_integrity_i (trans.req.integrity),
    .trans_we_i        (trans.req.we),
    .obi_req_i         (trans.valid),
    .obi_gnt_i         (obi.gnt),
    .obi_rvalid_i      (obi.rvalid),
    .obi_resp_i        (obi.resp_payload),
    .gntpar_err_resp_o (gntpar_err_resp),
    .integrity_resp_o  (integrity_resp),
    .rchk_err_resp_o   (rchk_err_resp)
  );

endmodule

`default_nettype wire

/* verilog/obi_data_subsys.sv */
// Data memory port top level joining the load/store front end and the OBI adapter
`default_nettype none

module obi_data_subsys #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Core side
  input  logic                        core_req_i,
  output logic                        core_ready_o,
  input  logic [obi_pkg::ADDR_W-1:0]  core_addr_i,
  input  logic                        core_we_i,
  input  obi_pkg::size_e              core_size_i,
  input  logic                        core_signed_i,
  input  logic [obi_pkg::DATA_W-1:0]  core_wdata_i,
  output logic                        core_rvalid_o,
  output logic [obi_pkg::DATA_W-1:0]  core_rdata_o,
  output logic                        core_err_o,
  output logic                        integrity_err_o,
  // OBI A channel
  output logic                        obi_req_o,
  output logic                        obi_reqpar_o,
  output logic [obi_pkg::ADDR_W-1:0]  obi_addr_o,
  output logic                        obi_we_o,
  output logic [3:0]                  obi_be_o,
  output logic [obi_pkg::DATA_W-1:0]  obi_wdata_o,
  output logic [obi_pkg::ACHK_W-1:0]  obi_achk_o,
  input  logic                        obi_gnt_i,
  input  logic                        obi_gntpar_i,
  // OBI R channel
  input  logic                        obi_rvalid_i,
  input  logic                        obi_rvalidpar_i,
  input  logic [obi_pkg::DATA_W-1:0]  obi_rdata_i,
  input  logic                        obi_err_i,
  input  logic [obi_pkg::RCHK_W-1:0]  obi_rchk_i
);

  logic               resp_valid;
  obi_pkg::obi_resp_t resp;

  trans_if u_trans_if ();
  obi_if   u_obi_if ();

  //////////////////////////////
  // Bus pins
  //////////////////////////////

  assign obi_req_o    = u_obi_if.req;
  assign obi_reqpar_o = u_obi_if.reqpar;
  assign obi_addr_o   = u_obi_if.req_payload.addr;
  assign obi_we_o     = u_obi_if.req_payload.we;
  assign obi_be_o     = u_obi_if.req_payload.be;
  assign obi_wdata_o  = u_obi_if.req_payload.wdata;
  assign obi_achk_o   = u_obi_if.req_payload.achk;

  assign u_obi_if.gnt       = obi_gnt_i;
  assign u_obi_if.gntpar    = obi_gntpar_i;
  assign u_obi_if.rvalid    = obi_rvalid_i;
  assign u_obi_if.rvalidpar = obi_rvalidpar_i;
  // Integrity fields are filled in by the adapter
  assign u_obi_if.resp_payload = '{rdata: obi_rdata_i, err: obi_err_i, rchk: obi_rchk_i,
                                   integrity: 1'b0, integrity_err: 1'b0};

  lsu_obi_front #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_lsu_obi_front (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .core_req_i    (core_req_i),
    .core_ready_o  (core_ready_o),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_size_i   (core_size_i),
    .core_signed_i (core_signed_i),
    .core_wdata_i  (core_wdata_i),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .core_err_o    (core_err_o),
    .trans         (u_trans_if.front),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp)
  );

  data_obi_interface #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_data_obi_interface (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .trans           (u_trans_if.adapter),
    .resp_valid_o    (resp_valid),
    .resp_o          (resp),
    .integrity_err_o (integrity_err_o),
    .obi             (u_obi_if.master)
  );

endmodule

`default_nettype wire

/* tb/tb_obi_data_subsys.sv */
// Random-stimulus testbench for the OBI data port with a bus memory model and reference model
`default_nettype none

module tb_obi_data_subsys;

  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int unsigned N_TRANS         = 400;
  // Generous bound for random grants and response delays
  localparam int unsigned TIMEOUT_CYCLES  = 20 * N_TRANS;
  localparam int unsigned MEM_WORDS       = 128;
  localparam logic [31:0] SEED            = 32'hd3eb_52f5;

  // Response waiting inside the memory model
  typedef struct packed {
    logic [31:0] word;
    logic        err;
    logic [31:0] due;
  } mem_rsp_t;

  // Response the core should see
  typedef struct packed {
    logic        we;
    logic        prot;
    logic [31:0] rdata;
  } exp_rsp_t;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       core_req_i;
  logic                       core_ready_o;
  logic [31:0]                core_addr_i;
  logic                       core_we_i;
  obi_pkg::size_e             core_size_i;
  logic                       core_signed_i;
  logic [31:0]                core_wdata_i;
  logic                       core_rvalid_o;
  logic [31:0]                core_rdata_o;
  logic                       core_err_o;
  logic                       integrity_err_o;
  logic                       obi_req_o;
  logic                       obi_reqpar_o;
  logic [31:0]                obi_addr_o;
  logic                       obi_we_o;
  logic [3:0]                 obi_be_o;
  logic [31:0]                obi_wdata_o;
  logic [obi_pkg::ACHK_W-1:0] obi_achk_o;
  logic                       obi_gnt_i;
  logic                       obi_gntpar_i;
  logic                       obi_rvalid_i;
  logic                       obi_rvalidpar_i;
  logic [31:0]                obi_rdata_i;
  logic                       obi_err_i;
  logic [obi_pkg::RCHK_W-1:0] obi_rchk_i;

  // Bus memory and the reference model's own copy
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  mem_rsp_t    mem_q[$];
  exp_rsp_t    exp_q[$];
  int unsigned n_out     = 0;
  int unsigned n_issued  = 0;
  int unsigned n_resp    = 0;
  int unsigned cyc       = 0;
  int unsigned cycle_cnt = 0;
  logic        req_taken = 1'b0;

  obi_data_subsys #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_obi_data_subsys (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .core_req_i      (core_req_i),
    .core_ready_o    (core_ready_o),
    .core_addr_i     (core_addr_i),
    .core_we_i       (core_we_i),
    .core_size_i     (core_size_i),
    .core_signed_i   (core_signed_i),
    .core_wdata_i    (core_wdata_i),
    .core_rvalid_o   (core_rvalid_o),
    .core_rdata_o    (core_rdata_o),
    .core_err_o      (core_err_o),
    .integrity_err_o (integrity_err_o),
    .obi_req_o       (obi_req_o),
    .obi_reqpar_o    (obi_reqpar_o),
    .obi_addr_o      (obi_addr_o),
    .obi_we_o        (obi_we_o),
    .obi_be_o        (obi_be_o),
    .obi_wdata_o     (obi_wdata_o),
    .obi_achk_o      (obi_achk_o),
    .obi_gnt_i       (obi_gnt_i),
    .obi_gntpar_i    (obi_gntpar_i),
    .obi_rvalid_i    (obi_rvalid_i),
    .obi_rvalidpar_i (obi_rvalidpar_i),
    .obi_rdata_i     (obi_rdata_i),
    .obi_err_i       (obi_err_i),
    .obi_rchk_i      (obi_rchk_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Rule helpers
  //////////////////////////////

  function automatic int size_bytes(obi_pkg::size_e size);
    return (size == obi_pkg::SIZE_BYTE) ? 1 : (size == obi_pkg::SIZE_HALF) ? 2 : 4;
  endfunction

  // One enable per byte the access touches
  function automatic logic [3:0] calc_be(obi_pkg::size_e size, logic [1:0] off);
    logic [3:0] be;
    be = '0;
    for (int i = 0; i < size_bytes(size); i++) be[off + i] = 1'b1;
    return be;
  endfunction

  function automatic logic [11:0] calc_achk(logic [31:0] addr, logic we, logic [3:0] be,
                                            logic [31:0] wdata);
    logic [11:0] c;
    for (int i = 0; i < 4; i++) begin
      c[8 + i] = ^wdata[8*i +: 8];
      c[i]     = ^addr[8*i +: 8];
    end
    // Zero atop, zero dbg, be with we, zero prot and memtype
    c[7] = 1'b0;
    c[6] = 1'b1;
    c[5] = !(^{be, we});
    c[4] = 1'b1;
    return c;
  endfunction

  function automatic logic [4:0] calc_rchk(logic [31:0] rdata, logic err);
    logic [4:0] c;
    for (int i = 0; i < 4; i++) c[i] = ^rdata[8*i +: 8];
    c[4] = err;
    return c;
  endfunction

  // Bus-side write through byte enables
  function automatic logic [31:0] merge_bytes(logic [31:0] word, logic [3:0] be,
                                              logic [31:0] data);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) word[8*i +: 8] = data[8*i +: 8];
    end
    return word;
  endfunction

  // Core-side store puts the low data bytes on the addressed bytes
  function automatic logic [31:0] store_core(logic [31:0] word, obi_pkg::size_e size,
                                             logic [1:0] off, logic [31:0] data);
    for (int i = 0; i < size_bytes(size); i++) word[8*(off + i) +: 8] = data[8*i +: 8];
    return word;
  endfunction

  function automatic logic [31:0] extract_load(logic [31:0] word, obi_pkg::size_e size,
                                               logic [1:0] off, logic sign);
    logic [31:0] v;
    v = word >> (8 * off);
    case (size)
      obi_pkg::SIZE_BYTE: v = sign ? {{24{v[7]}}, v[7:0]} : {24'd0, v[7:0]};
      obi_pkg::SIZE_HALF: v = sign ? {{16{v[15]}}, v[15:0]} : {16'd0, v[15:0]};
      default: v = word;
    endcase
    return v;
  endfunction

  // Initial memory content unique per word
  function automatic logic [31:0] fill_word(int idx);
    return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ 32'(idx);
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_hex(string name, logic [31:0] got, logic [31:0] expected);
    assert (got === expected)
      else fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, expected));
  endtask

  //////////////////////////////
  // Per-cycle checks and models
  //////////////////////////////

  // Runs at the falling edge and sees what the coming rising edge will do
  task automatic check_cycle();
    logic        full;
    logic        ierr;
    logic [1:0]  off;
    logic [3:0]  be;
    logic [6:0]  idx;
    exp_rsp_t    e;
    mem_rsp_t    m;
    full = (n_out == MAX_OUTSTANDING);
    // Parity is good when it is the inverse of its signal
    ierr = (obi_gnt_i == obi_gntpar_i) || (obi_rvalid_i == obi_rvalidpar_i);
    check_hex("obi_req_o", obi_req_o, core_req_i && !full);
    check_hex("obi_reqpar_o", obi_reqpar_o, !(core_req_i && !full));
    if (core_req_i) begin
      check_hex("core_ready_o", core_ready_o, obi_gnt_i && !full);
    end
    check_hex("core_rvalid_o", core_rvalid_o, obi_rvalid_i);
    // R channel answers the oldest transfer first
    if (obi_rvalid_i) begin
      e = exp_q.pop_front();
      check_hex("core_err_o", core_err_o, obi_err_i);
      if (!e.we) begin
        check_hex("core_rdata_o", core_rdata_o, e.rdata);
      end
      // Check code only counts on protected reads
      ierr = ierr || (e.prot && !e.we && (obi_rchk_i != calc_rchk(obi_rdata_i, obi_err_i)));
      n_out--;
      n_resp++;
    end
    check_hex("integrity_err_o", integrity_err_o, ierr);
    // A channel transfer completes at the coming edge
    if (obi_req_o && obi_gnt_i) begin
      off = core_addr_i[1:0];
      be  = calc_be(core_size_i, off);
      check_hex("obi_addr_o", obi_addr_o, core_addr_i);
      check_hex("obi_we_o", obi_we_o, core_we_i);
      check_hex("obi_be_o", obi_be_o, be);
      check_hex("obi_wdata_o", obi_wdata_o, core_wdata_i << (8 * off));
      check_hex("obi_achk_o", obi_achk_o,
                calc_achk(core_addr_i, core_we_i, be, core_wdata_i << (8 * off)));
      // Reference model from the core request
      idx     = core_addr_i[8:2];
      e.we    = core_we_i;
      e.prot  = core_addr_i[obi_pkg::INTEGRITY_ADDR_BIT];
      e.rdata = extract_load(ref_mem[idx], core_size_i, off, core_signed_i);
      if (core_we_i) begin
        ref_mem[idx] = store_core(ref_mem[idx], core_size_i, off, core_wdata_i);
      end
      exp_q.push_back(e);
      // Memory model from the bus pins
      m.word = mem[obi_addr_o[8:2]];
      m.err  = ($urandom % 8) == 0;
      m.due  = cyc + 1 + ($urandom % 4);
      if (obi_we_o) begin
        mem[obi_addr_o[8:2]] = merge_bytes(mem[obi_addr_o[8:2]], obi_be_o, obi_wdata_o);
      end
      mem_q.push_back(m);
      n_out++;
    end
    req_taken = core_req_i && core_ready_o;
  endtask

  // New core request once the previous one is taken
  task automatic drive_core();
    logic [31:0]    a;
    obi_pkg::size_e sz;
    if (!core_req_i || req_taken) begin
      if (n_issued < N_TRANS && ($urandom % 4) != 0) begin
        a  = $urandom;
        sz = obi_pkg::size_e'($urandom % 3);
        // Naturally aligned accesses only
        if (sz == obi_pkg::SIZE_HALF) a[0] = 1'b0;
        if (sz == obi_pkg::SIZE_WORD) a[1:0] = 2'b00;
        core_req_i    <= 1'b1;
        core_addr_i   <= a;
        core_size_i   <= sz;
        core_we_i     <= $urandom % 2;
        core_signed_i <= $urandom % 2;
        core_wdata_i  <= $urandom;
        n_issued++;
      end else begin
        core_req_i <= 1'b0;
      end
    end
  endtask

  // Random grants, in-order responses, occasional parity and check code faults
  task automatic drive_bus();
    logic       g;
    logic       rv;
    logic [4:0] flip;
    mem_rsp_t   m;
    cyc++;
    g  = ($urandom % 3) != 0;
    rv = 1'b0;
    obi_gnt_i    <= g;
    obi_gntpar_i <= !g ^ (($urandom % 16) == 0);
    if (mem_q.size() != 0) begin
      if (mem_q[0].due <= cyc) begin
        m  = mem_q.pop_front();
        rv = 1'b1;
      end
    end
    if (rv) begin
      flip = (($urandom % 6) == 0) ? 5'(1 << ($urandom % 5)) : 5'd0;
      obi_rdata_i <= m.word;
      obi_err_i   <= m.err;
      obi_rchk_i  <= calc_rchk(m.word, m.err) ^ flip;
    end else begin
      obi_rdata_i <= '0;
      obi_err_i   <= 1'b0;
      obi_rchk_i  <= '0;
    end
    obi_rvalid_i    <= rv;
    obi_rvalidpar_i <= !rv ^ (($urandom % 16) == 0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n_i         <= 1'b0;
    core_req_i      <= 1'b0;
    core_addr_i     <= '0;
    core_we_i       <= 1'b0;
    core_size_i     <= obi_pkg::SIZE_WORD;
    core_signed_i   <= 1'b0;
    core_wdata_i    <= '0;
    obi_gnt_i       <= 1'b0;
    obi_gntpar_i    <= 1'b1;
    obi_rvalid_i    <= 1'b0;
    obi_rvalidpar_i <= 1'b1;
    obi_rdata_i     <= '0;
    obi_err_i       <= 1'b0;
    obi_rchk_i      <= '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (n_resp < N_TRANS) begin
      @(negedge clk_i);
      check_cycle();
      @(posedge clk_i);
      drive_core();
      drive_bus();
    end
    $display("Simulation completed successfully");
    $finish;
  end

  // Hang guard
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d responses", cycle_cnt, n_resp,
               N_TRANS);
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/obi_pkg.sv
verilog/trans_if.sv
verilog/obi_if.sv
verilog/obi_integrity_fifo.sv
verilog/lsu_obi_front.sv
verilog/data_obi_interface.sv
verilog/obi_data_subsys.sv
tb/tb_obi_data_subsys.sv

/* Bender.yml */
package:
  name: obi_data_subsys

sources:
  - verilog/obi_pkg.sv
  - verilog/trans_if.sv
  - verilog/obi_if.sv
  - verilog/obi_integrity_fifo.sv
  - verilog/lsu_obi_front.sv
  - verilog/data_obi_interface.sv
  - verilog/obi_data_subsys.sv
  - target: test
    files:
      - tb/tb_obi_data_subsys.sv
